//--- Makefile
VERILATOR  ?= verilator
TOP        := cdw_tb
FILELIST   := files.f
LINT_FLAGS := --lint-only --timing --assert -sv
SIM_FLAGS  := --binary --timing --assert -sv -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "Simulation ended without a pass line"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+hw
hw/cdw_pkg.sv
hw/ddt_addr_gen.sv
hw/dc_field_check.sv
hw/cdw_walker.sv
hw/cdw_top.sv
tb/cdw_chk.sv
tb/cdw_tb.sv

//--- hw/cdw_pkg.sv
// Types for the device-context walker: bus structs, entry layouts, caps and causes
// Imported by every module that handles bus traffic or directory data
`include "cdw_settings.svh"

package cdw_pkg;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`CDW_PLEN-1:0]      adr;
        logic [`CDW_DW_W/8-1:0]    sel;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic                 ack;
        logic                 err;
        logic [`CDW_DW_W-1:0] dat;
    } wb_rsp_t;

    // ddtp.MODE encoding
    typedef enum logic [3:0] {
        DDT_OFF  = 4'd0,
        DDT_BARE = 4'd1,
        DDT_1LVL = 4'd2,
        DDT_2LVL = 4'd3,
        DDT_3LVL = 4'd4
    } ddt_mode_t;

    // Non-leaf directory entry
    typedef struct packed {
        logic [9:0]            reserved_hi;
        logic [`CDW_PPN_W-1:0] ppn;
        logic [8:0]            reserved_lo;
        logic                  v;
    } nl_entry_t;

    // DC.tc, doubleword 0
    typedef struct packed {
        logic [60:0] reserved;
        logic        t2gpa;
        logic        en_ats;
        logic        v;
    } dc_tc_t;

    // DC.iohgatp, doubleword 1
    typedef struct packed {
        logic [3:0]            mode;
        logic [15:0]           gscid;
        logic [`CDW_PPN_W-1:0] ppn;
    } dc_iohgatp_t;

    // DC.ta, doubleword 2
    typedef struct packed {
        logic [31:0] reserved_hi;
        logic [19:0] pscid;
        logic [11:0] reserved_lo;
    } dc_ta_t;

    // DC.fsc, doubleword 3
    typedef struct packed {
        logic [3:0]            mode;
        logic [15:0]           reserved;
        logic [`CDW_PPN_W-1:0] ppn;
    } dc_fsc_t;

    // Base context, tc in the low doubleword as in memory
    typedef struct packed {
        dc_fsc_t     fsc;
        dc_ta_t      ta;
        dc_iohgatp_t iohgatp;
        dc_tc_t      tc;
    } dc_t;

    // Capability bits that the checks depend on
    typedef struct packed {
        logic t2gpa;
        logic sv39x4;
        logic sv48x4;
        logic sv57x4;
    } caps_t;

    // Fault causes raised by the walk
    typedef enum logic [11:0] {
        DDT_ENTRY_INVALID       = 12'd258,
        DDT_ENTRY_MISCONFIGURED = 12'd259,
        DDT_DATA_CORRUPTION     = 12'd268
    } cause_t;

    // Which doubleword the field checker judges
    typedef enum logic [2:0] {
        CHK_NL      = 3'd0,
        CHK_TC      = 3'd1,
        CHK_IOHGATP = 3'd2,
        CHK_TA      = 3'd3,
        CHK_FSC     = 3'd4
    } chk_kind_t;

endpackage

//--- hw/cdw_settings.svh
// Fixed widths and counts shared by the device-context walker
// Include wherever a width below is needed
`ifndef CDW_SETTINGS_SVH
`define CDW_SETTINGS_SVH

// Physical page number width
`define CDW_PPN_W 44

// Physical address width
`define CDW_PLEN 56

// Device ID width
`define CDW_DID_W 24

// Memory doubleword width
`define CDW_DW_W 64

// Doublewords in a base-format device context
`define CDW_DC_DWS 4

`endif

//--- hw/cdw_top.sv
// Device-context walker top: joins the walk engine, pointer generator and checker
// Drive start_i while busy_o is low; results come with done_o or error_o
`timescale 1ns/1ps
`include "cdw_settings.svh"

module cdw_top import cdw_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  start_i,
    input  logic [`CDW_DID_W-1:0] did_i,
    input  logic [`CDW_PPN_W-1:0] ddtp_ppn_i,
    input  ddt_mode_t             ddtp_mode_i,
    input  caps_t                 caps_i,
    input  wb_rsp_t               wb_rsp_i,
    output wb_req_t               wb_req_o,
    output logic                  busy_o,
    output logic                  done_o,
    output logic                  error_o,
    output cause_t                cause_o,
    output logic [`CDW_DID_W-1:0] did_o,
    output dc_t                   dc_o
);

    logic [1:0]            level;
    logic                  root;
    logic [`CDW_PPN_W-1:0] ppn;
    logic [`CDW_PLEN-1:0]  pptr;
    chk_kind_t             kind;
    dc_tc_t                tc;
    logic                  invalid;
    logic                  misconf;

    cdw_walker walker_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i),
        .did_i       (did_i),
        .ddtp_ppn_i  (ddtp_ppn_i),
        .ddtp_mode_i (ddtp_mode_i),
        .wb_req_o    (wb_req_o),
        .wb_rsp_i    (wb_rsp_i),
        .level_o     (level),
        .root_o      (root),
        .did_o       (did_o),
        .ppn_o       (ppn),
        .pptr_i      (pptr),
        .kind_o      (kind),
        .tc_o        (tc),
        .invalid_i   (invalid),
        .misconf_i   (misconf),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .error_o     (error_o),
        .cause_o     (cause_o),
        .dc_o        (dc_o)
    );

    // Shares the walker's device ID output
    ddt_addr_gen addr_gen_i (
        .level_i (level),
        .root_i  (root),
        .did_i   (did_o),
        .ppn_i   (ppn),
        .pptr_o  (pptr)
    );

    // Judges the read data straight off the bus
    dc_field_check field_check_i (
        .kind_i    (kind),
        .data_i    (wb_rsp_i.dat),
        .tc_i      (tc),
        .caps_i    (caps_i),
        .invalid_o (invalid),
        .misconf_o (misconf)
    );

endmodule

//--- hw/cdw_walker.sv
// Walk engine: DDT levels, base context load and the Wishbone read master
// Addresses and field verdicts come from ddt_addr_gen and dc_field_check
`timescale 1ns/1ps
`include "cdw_settings.svh"

module cdw_walker import cdw_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Request side
    input  logic                  start_i,
    input  logic [`CDW_DID_W-1:0] did_i,
    input  logic [`CDW_PPN_W-1:0] ddtp_ppn_i,
    input  ddt_mode_t             ddtp_mode_i,

    // Bus side
    output wb_req_t               wb_req_o,
    input  wb_rsp_t               wb_rsp_i,

    // To and from the address generator
    output logic [1:0]            level_o,
    output logic                  root_o,
    output logic [`CDW_DID_W-1:0] did_o,
    output logic [`CDW_PPN_W-1:0] ppn_o,
    input  logic [`CDW_PLEN-1:0]  pptr_i,

    // To and from the field checker
    output chk_kind_t             kind_o,
    output dc_tc_t                tc_o,
    input  logic                  invalid_i,
    input  logic                  misconf_i,

    // Result
    output logic                  busy_o,
    output logic                  done_o,
    output logic                  error_o,
    output cause_t                cause_o,
    output dc_t                   dc_o
);

    localparam int DwCntW = $clog2(`CDW_DC_DWS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_LEAF,
        S_FINISH,
        S_ERROR
    } state_e;

    state_e              state_q, state_n;
    // Levels left, 1 means the context level
    logic [1:0]          level_q, level_n;
    logic [1:0]          start_lvl;
    logic [DwCntW-1:0]   dw_cnt_q, dw_cnt_n;

    logic [`CDW_PLEN-1:0]  addr_q, addr_n;
    logic [`CDW_DID_W-1:0] did_q;
    dc_t                   dc_q;
    cause_t                cause_q, cause_n;

    nl_entry_t rsp_nl;
    logic      in_leaf;
    logic      last_dw;
    logic      accept;
    logic      cap_en;

    assign rsp_nl  = nl_entry_t'(wb_rsp_i.dat);
    assign in_leaf = (level_q == 2'd1);
    assign last_dw = (dw_cnt_q == DwCntW'(`CDW_DC_DWS - 1));

    // Levels to walk for each mode, zero when no walk is possible
    always_comb begin
        case (ddtp_mode_i)
            DDT_3LVL: start_lvl = 2'd3;
            DDT_2LVL: start_lvl = 2'd2;
            DDT_1LVL: start_lvl = 2'd1;
            default:  start_lvl = 2'd0;
        endcase
    end

    // Address generator inputs
    // In idle the root pointer is prepared from the request inputs
    assign root_o  = (state_q == S_IDLE);
    assign level_o = root_o ? start_lvl : level_q;
    assign did_o   = root_o ? did_i : did_q;
    assign ppn_o   = root_o ? ddtp_ppn_i : rsp_nl.ppn;

    // Checker kind follows the level and then the doubleword index
    always_comb begin
        if (!in_leaf) begin
            kind_o = CHK_NL;
        end else begin
            case (dw_cnt_q)
                DwCntW'(0): kind_o = CHK_TC;
                DwCntW'(1): kind_o = CHK_IOHGATP;
                DwCntW'(2): kind_o = CHK_TA;
                default:    kind_o = CHK_FSC;
            endcase
        end
    end

    assign tc_o = dc_q.tc;

    // Classic read, one doubleword per cycle of stb
    assign wb_req_o.cyc = (state_q == S_REQ);
    assign wb_req_o.stb = (state_q == S_REQ);
    assign wb_req_o.we  = 1'b0;
    assign wb_req_o.adr = addr_q;
    assign wb_req_o.sel = '1;

    assign busy_o  = (state_q != S_IDLE);
    assign done_o  = (state_q == S_FINISH);
    assign error_o = (state_q == S_ERROR);
    assign cause_o = cause_q;
    assign dc_o    = dc_q;

    always_comb begin
        state_n  = state_q;
        level_n  = level_q;
        dw_cnt_n = dw_cnt_q;
        addr_n   = addr_q;
        cause_n  = cause_q;
        accept   = 1'b0;
        cap_en   = 1'b0;

        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    accept   = 1'b1;
                    level_n  = start_lvl;
                    dw_cnt_n = '0;
                    addr_n   = pptr_i;
                    // Off and bare have no directory to walk
                    if (start_lvl == 2'd0) begin
                        cause_n = DDT_ENTRY_INVALID;
                        state_n = S_ERROR;
                    end else begin
                        state_n = S_REQ;
                    end
                end
            end

            S_REQ: begin
                // Bus error beats any field verdict
                if (wb_rsp_i.err) begin
                    cause_n = DDT_DATA_CORRUPTION;
                    state_n = S_ERROR;
                end else if (wb_rsp_i.ack) begin
                    cap_en = in_leaf;
                    if (invalid_i) begin
                        cause_n = DDT_ENTRY_INVALID;
                        state_n = S_ERROR;
                    end else if (misconf_i) begin
                        cause_n = DDT_ENTRY_MISCONFIGURED;
                        state_n = S_ERROR;
                    end else if (!in_leaf) begin
                        // Next table from the entry PPN
                        level_n = level_q - 2'd1;
                        addr_n  = pptr_i;
                        state_n = S_WAIT;
                    end else if (last_dw) begin
                        state_n = S_FINISH;
                    end else begin
                        dw_cnt_n = dw_cnt_q + 1'b1;
                        addr_n   = addr_q + `CDW_PLEN'(8);
                        state_n  = S_LEAF;
                    end
                end
            end

            // One idle bus cycle between accesses
            S_WAIT, S_LEAF: begin
                state_n = S_REQ;
            end

            // Result pulses last a single cycle
            S_FINISH, S_ERROR: begin
                state_n = S_IDLE;
            end

            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= S_IDLE;
            level_q  <= 2'd0;
            dw_cnt_q <= '0;
        end else begin
            state_q  <= state_n;
            level_q  <= level_n;
            dw_cnt_q <= dw_cnt_n;
        end
    end

    // Address, device ID, cause and context
    always_ff @(posedge clk_i) begin
        addr_q  <= addr_n;
        cause_q <= cause_n;
        if (accept) begin
            did_q <= did_i;
        end
        // Context slot picked by the doubleword index
        if (cap_en) begin
            case (dw_cnt_q)
                DwCntW'(0): dc_q.tc      <= dc_tc_t'(wb_rsp_i.dat);
                DwCntW'(1): dc_q.iohgatp <= dc_iohgatp_t'(wb_rsp_i.dat);
                DwCntW'(2): dc_q.ta      <= dc_ta_t'(wb_rsp_i.dat);
                default:    dc_q.fsc     <= dc_fsc_t'(wb_rsp_i.dat);
            endcase
        end
    end

endmodule

//--- hw/dc_field_check.sv
// Validity and configuration checks on one fetched directory doubleword
// Combinational, the kind input selects which rules apply
`timescale 1ns/1ps
`include "cdw_settings.svh"

module dc_field_check import cdw_pkg::*; (
    input  chk_kind_t             kind_i,
    input  logic [`CDW_DW_W-1:0]  data_i,
    input  dc_tc_t                tc_i,
    input  caps_t                 caps_i,
    output logic                  invalid_o,
    output logic                  misconf_o
);

    // Views of the same data word
    nl_entry_t   nl;
    dc_tc_t      tc;
    dc_iohgatp_t gatp;
    dc_ta_t      ta;
    dc_fsc_t     fsc;

    logic gatp_mode_ok;
    logic gatp_cap_ok;
    logic fsc_mode_ok;

    assign nl   = nl_entry_t'(data_i);
    assign tc   = dc_tc_t'(data_i);
    assign gatp = dc_iohgatp_t'(data_i);
    assign ta   = dc_ta_t'(data_i);
    assign fsc  = dc_fsc_t'(data_i);

    // Bare, Sv39x4, Sv48x4, Sv57x4
    assign gatp_mode_ok = gatp.mode inside {4'd0, 4'd8, 4'd9, 4'd10};

    // Each G-stage mode needs its capability
    assign gatp_cap_ok = !((gatp.mode == 4'd8  && !caps_i.sv39x4) ||
                           (gatp.mode == 4'd9  && !caps_i.sv48x4) ||
                           (gatp.mode == 4'd10 && !caps_i.sv57x4));

    // Bare, Sv39, Sv48, Sv57
    assign fsc_mode_ok = fsc.mode inside {4'd0, 4'd8, 4'd9, 4'd10};

    always_comb begin
        invalid_o = 1'b0;
        misconf_o = 1'b0;
        case (kind_i)
            CHK_NL: begin
                invalid_o = !nl.v;
                misconf_o = (|nl.reserved_lo) || (|nl.reserved_hi);
            end
            CHK_TC: begin
                invalid_o = !tc.v;
                // T2GPA needs both ATS and the capability
                misconf_o = (|tc.reserved) ||
                            (tc.t2gpa && !tc.en_ats) ||
                            (tc.t2gpa && !caps_i.t2gpa);
            end
            CHK_IOHGATP: begin
                // T2GPA is judged against the tc captured one read earlier
                // A nonzero mode needs a 16 KiB aligned root
                misconf_o = !gatp_mode_ok || !gatp_cap_ok ||
                            (gatp.mode == 4'd0 && tc_i.t2gpa) ||
                            (gatp.mode != 4'd0 && (|gatp.ppn[1:0]));
            end
            CHK_TA: begin
                misconf_o = (|ta.reserved_lo) || (|ta.reserved_hi);
            end
            CHK_FSC: begin
                misconf_o = (|fsc.reserved) || !fsc_mode_ok;
            end
            default: begin
                misconf_o = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/ddt_addr_gen.sv
// Directory pointer generator, combinational
// Forms the address of the next DDT read from a PPN and the device ID slice
`timescale 1ns/1ps
`include "cdw_settings.svh"

module ddt_addr_gen (
    input  logic [1:0]            level_i,
    input  logic                  root_i,
    input  logic [`CDW_DID_W-1:0] did_i,
    input  logic [`CDW_PPN_W-1:0] ppn_i,
    output logic [`CDW_PLEN-1:0]  pptr_o
);

    // Level whose slice indexes the table being pointed at
    logic [1:0]  slice_lvl;
    // Page offset, 12 bits
    logic [11:0] offset;

    // At the root the start level picks the slice
    // After a non-leaf entry the next lower slice is used
    assign slice_lvl = root_i ? level_i : level_i - 2'd1;

    always_comb begin
        case (slice_lvl)
            // Top slice is only 8 bits, zero-extended to 9
            2'd3:    offset = {1'b0, did_i[23:16], 3'b000};
            2'd2:    offset = {did_i[15:7], 3'b000};
            // Leaf table holds 32-byte contexts
            2'd1:    offset = {did_i[6:0], 5'b00000};
            default: offset = '0;
        endcase
    end

    assign pptr_o = {ppn_i, offset};

endmodule

//--- tb/cdw_chk.sv
// Wishbone and result-pulse assertions, bound into every cdw_walker instance
`timescale 1ns/1ps

module cdw_chk import cdw_pkg::*; (
    input logic    clk_i,
    input logic    rst_ni,
    input wb_req_t wb_req_o,
    input wb_rsp_t wb_rsp_i,
    input logic    done_o,
    input logic    error_o
);

    // Strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_req_o.stb |-> wb_req_o.cyc)
        else $error("stb high while cyc is low");

    // Read-only master
    never_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !wb_req_o.we)
        else $error("we raised by a read-only master");

    // Request held until the slave answers
    adr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_req_o.stb && !wb_rsp_i.ack && !wb_rsp_i.err) |=>
            (wb_req_o.stb && $stable(wb_req_o.adr)))
        else $error("address or stb changed before ack or err");

    // One outcome per walk
    one_outcome: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(done_o && error_o))
        else $error("done_o and error_o high together");

endmodule

bind cdw_walker cdw_chk chk_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_o (wb_req_o),
    .wb_rsp_i (wb_rsp_i),
    .done_o   (done_o),
    .error_o  (error_o)
);

//--- tb/cdw_tb.sv
// Testbench that builds DDT images in a sparse memory slave
// and compares each walk outcome with a reference walk over the same image
`timescale 1ns/1ps
`include "cdw_settings.svh"

module cdw_tb import cdw_pkg::*; ();

    localparam logic [31:0] SEED = 32'haaba_f44e;

    // Test scenarios cycled through in order
    localparam int SC_NL_INV  = 2;
    localparam int SC_TC_INV  = 3;
    localparam int SC_CAP     = 4;
    localparam int SC_TA_RES  = 5;
    localparam int SC_NO_ATS  = 6;
    localparam int SC_POISON  = 7;
    localparam int SC_OFF     = 8;
    localparam int SC_BUSY    = 9;
    localparam int NUM_SCEN   = 10;
    localparam int NUM_TESTS  = 40;

    // Budget of four accesses per test at four wait states each
    localparam int ACC_PER_TEST = 4;
    localparam int WAIT_BOUND   = 4;
    localparam int CYCLE_LIMIT  = NUM_TESTS * ACC_PER_TEST * (WAIT_BOUND + 2) + 100;

    // Page whose whole range answers with err
    localparam logic [`CDW_PPN_W-1:0] POISON_PPN = 44'h0_000b_ad00;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  start_i;
    logic [`CDW_DID_W-1:0] did_i;
    logic [`CDW_PPN_W-1:0] ddtp_ppn_i;
    ddt_mode_t             ddtp_mode_i;
    caps_t                 caps_i;
    wb_rsp_t               wb_rsp_i;
    wb_req_t               wb_req_o;
    logic                  busy_o;
    logic                  done_o;
    logic                  error_o;
    cause_t                cause_o;
    logic [`CDW_DID_W-1:0] did_o;
    dc_t                   dc_o;

    // Sparse memory image
    logic [`CDW_DW_W-1:0] mem [logic [`CDW_PLEN-1:0]];
    logic [`CDW_PPN_W-1:0] next_ppn;

    // Separate LFSR streams for stimulus and slave wait states
    logic [31:0] stim_seed;
    logic [31:0] slave_seed;

    // Slave access state
    logic in_access;
    int   wait_left;

    // Expected outcome of the walk in flight
    logic                  exp_armed;
    logic                  exp_ok;
    logic [11:0]           exp_cause;
    logic [255:0]          exp_dc;
    logic [`CDW_DID_W-1:0] exp_did;
    int                    n_results;
    int                    cycles;

    cdw_top dut_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i),
        .did_i       (did_i),
        .ddtp_ppn_i  (ddtp_ppn_i),
        .ddtp_mode_i (ddtp_mode_i),
        .caps_i      (caps_i),
        .wb_rsp_i    (wb_rsp_i),
        .wb_req_o    (wb_req_o),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .error_o     (error_o),
        .cause_o     (cause_o),
        .did_o       (did_o),
        .dc_o        (dc_o)
    );

    always #5 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic lfsr_step(inout logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        state = {state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(inout logic [31:0] state, input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step(state)};
        end
        return v;
    endfunction

    // Unwritten words read back as an address-derived pattern
    function automatic logic [63:0] mem_read(input logic [`CDW_PLEN-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a, 8'h00} ^ 64'h5a5a_5a5a_5a5a_5a5a;
    endfunction

    function automatic logic poisoned(input logic [`CDW_PLEN-1:0] a);
        return a[`CDW_PLEN-1:12] == POISON_PPN;
    endfunction

    function automatic logic [`CDW_PPN_W-1:0] alloc_page();
        next_ppn = next_ppn + 44'd1;
        return next_ppn;
    endfunction

    // Page offset of the device ID slice that indexes a table at this level
    function automatic logic [11:0] did_slice(input logic [23:0] did, input int lvl);
        case (lvl)
            3:       return {1'b0, did[23:16], 3'b000};
            2:       return {did[15:7], 3'b000};
            default: return {did[6:0], 5'b00000};
        endcase
    endfunction

    function automatic logic [3:0] pick_mode(input logic [1:0] s);
        case (s)
            2'd0:    return 4'd0;
            2'd1:    return 4'd8;
            2'd2:    return 4'd9;
            default: return 4'd10;
        endcase
    endfunction

    function automatic logic mode_legal(input logic [3:0] m);
        return (m == 4'd0) || (m == 4'd8) || (m == 4'd9) || (m == 4'd10);
    endfunction

    // Walks the memory image by the directory and field rules
    function automatic void ref_walk(input logic [23:0] did, input logic [43:0] root,
                                     input logic [3:0] mode, input caps_t caps,
                                     output logic ok, output logic [11:0] cause,
                                     output logic [255:0] dc);
        int          levels;
        logic [43:0] page;
        logic [55:0] addr;
        logic [63:0] d;
        logic [3:0]  m;
        logic        bad;
        ok = 1'b0;
        cause = 12'd0;
        dc = '0;
        case (mode)
            4'd2:    levels = 1;
            4'd3:    levels = 2;
            4'd4:    levels = 3;
            default: levels = 0;
        endcase
        // Off and bare have no table
        if (levels == 0) begin
            cause = 12'd258;
            return;
        end
        page = root;
        for (int lvl = levels; lvl > 1; lvl--) begin
            addr = {page, did_slice(did, lvl)};
            if (poisoned(addr)) begin
                cause = 12'd268;
                return;
            end
            d = mem_read(addr);
            if (!d[0]) begin
                cause = 12'd258;
                return;
            end
            if ((|d[9:1]) || (|d[63:54])) begin
                cause = 12'd259;
                return;
            end
            page = d[53:10];
        end
        // Four context doublewords, tc first
        for (int k = 0; k < 4; k++) begin
            addr = {page, did_slice(did, 1)} + 56'(8 * k);
            if (poisoned(addr)) begin
                cause = 12'd268;
                return;
            end
            d = mem_read(addr);
            dc[64*k +: 64] = d;
            m = d[63:60];
            case (k)
                0: begin
                    if (!d[0]) begin
                        cause = 12'd258;
                        return;
                    end
                    bad = (|d[63:3]) || (d[2] && (!d[1] || !caps.t2gpa));
                end
                1: bad = !mode_legal(m) || (m == 4'd8 && !caps.sv39x4) ||
                         (m == 4'd9 && !caps.sv48x4) || (m == 4'd10 && !caps.sv57x4) ||
                         (m == 4'd0 && dc[2]) || (m != 4'd0 && (|d[1:0]));
                2: bad = (|d[11:0]) || (|d[63:32]);
                default: bad = (|d[59:44]) || !mode_legal(m);
            endcase
            if (bad) begin
                cause = 12'd259;
                return;
            end
        end
        ok = 1'b1;
    endfunction

    // Cause each scenario is built to produce or zero for a good walk
    function automatic logic [11:0] intended_cause(input int scen);
        case (scen)
            SC_NL_INV, SC_TC_INV, SC_OFF:  return 12'd258;
            SC_CAP, SC_TA_RES, SC_NO_ATS:  return 12'd259;
            SC_POISON:                     return 12'd268;
            default:                       return 12'd0;
        endcase
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(input string name, input logic [255:0] got,
                            input logic [255:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Writes the directory entries and context for one walk
    task automatic build_table(input logic [23:0] did, input int levels, input int scen,
                               output logic [43:0] root);
        logic [43:0] page;
        logic [43:0] nxt;
        logic [55:0] base;
        logic [63:0] entry;
        logic [63:0] tc;
        logic [63:0] gatp;
        logic [63:0] ta;
        logic [3:0]  gmode;
        logic        coin;
        logic        t2gpa;
        coin = rand_bits(stim_seed, 1) != 64'd0;
        // A one-level walk can only be poisoned at the root page
        if (scen == SC_POISON && (levels == 1 || coin)) begin
            root = POISON_PPN;
        end else begin
            root = alloc_page();
        end
        page = root;
        for (int lvl = levels; lvl > 1; lvl--) begin
            nxt = (scen == SC_POISON && lvl == 2) ? POISON_PPN : alloc_page();
            entry = {10'b0, nxt, 9'b0, 1'b1};
            if (scen == SC_NL_INV && lvl == levels) begin
                entry[0] = 1'b0;
            end
            mem[{page, did_slice(did, lvl)}] = entry;
            page = nxt;
        end
        base = {page, did_slice(did, 1)};
        t2gpa = rand_bits(stim_seed, 1) != 64'd0;
        tc = {61'b0, t2gpa, t2gpa | (rand_bits(stim_seed, 1) != 64'd0), 1'b1};
        if (scen == SC_TC_INV) tc[0] = 1'b0;
        // T2GPA set with ATS clear
        if (scen == SC_NO_ATS) tc[2:1] = 2'b10;
        gmode = pick_mode(2'(rand_bits(stim_seed, 2)));
        if (tc[2] && gmode == 4'd0) gmode = 4'd8;
        if (scen == SC_CAP) gmode = 4'd8;
        // Root PPN kept 16 KiB aligned
        gatp = {gmode, 16'(rand_bits(stim_seed, 16)), 42'(rand_bits(stim_seed, 42)), 2'b00};
        ta = {32'b0, 20'(rand_bits(stim_seed, 20)), 12'b0};
        if (scen == SC_TA_RES) ta[coin ? 40 : 5] = 1'b1;
        mem[base] = tc;
        mem[base + 56'd8] = gatp;
        mem[base + 56'd16] = ta;
        mem[base + 56'd24] = {pick_mode(2'(rand_bits(stim_seed, 2))), 16'b0,
                              44'(rand_bits(stim_seed, 44))};
    endtask

    task automatic run_test(input int t);
        int            scen;
        int            levels;
        logic [23:0]   did;
        logic [3:0]    mode;
        logic [43:0]   root;
        caps_t         caps;
        logic          ok;
        logic [11:0]   cause;
        logic [255:0]  dc;
        scen = t % NUM_SCEN;
        did = 24'(rand_bits(stim_seed, 24));
        levels = int'(rand_bits(stim_seed, 2));
        if (levels == 0) levels = 3;
        // Invalid non-leaf entry needs at least one directory level
        if (scen == SC_NL_INV && levels == 1) levels = 2;
        mode = 4'(levels + 1);
        if (scen == SC_OFF) mode = 4'(rand_bits(stim_seed, 1));
        caps = caps_t'(4'hf);
        if (scen == SC_CAP) caps.sv39x4 = 1'b0;
        build_table(did, levels, scen, root);
        ref_walk(did, root, mode, caps, ok, cause, dc);
        if (ok != (intended_cause(scen) == 12'd0) || cause != intended_cause(scen)) begin
            $display("Table for scenario %0d does not give its intended outcome", scen);
            abort_run();
        end
        exp_ok = ok;
        exp_cause = cause;
        exp_dc = dc;
        exp_did = did;
        exp_armed = 1'b1;
        @(negedge clk_i);
        did_i = did;
        ddtp_ppn_i = root;
        ddtp_mode_i = ddt_mode_t'(mode);
        caps_i = caps;
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        // Second request while the walk runs must be dropped
        if (scen == SC_BUSY) begin
            @(negedge clk_i);
            if (!busy_o) begin
                $display("Walk was no longer busy when the second start was due");
                abort_run();
            end
            did_i = ~did;
            ddtp_ppn_i = root + 44'd1;
            ddtp_mode_i = DDT_1LVL;
            start_i = 1'b1;
            @(negedge clk_i);
            start_i = 1'b0;
        end
        wait (n_results == t + 1);
    endtask

    // Memory slave with 0 to 3 wait states per access
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            wb_rsp_i = '0;
            in_access = 1'b0;
            wait_left = 0;
        end else if (wb_rsp_i.ack || wb_rsp_i.err) begin
            // Answer was taken at the last rising edge
            wb_rsp_i = '0;
        end else if (wb_req_o.stb) begin
            if (!in_access) begin
                in_access = 1'b1;
                wait_left = int'(rand_bits(slave_seed, 2));
            end
            if (wait_left == 0) begin
                in_access = 1'b0;
                // Every read asks for all eight bytes
                check_eq("wb_req_o.sel", 256'(wb_req_o.sel), 256'(8'hff));
                if (poisoned(wb_req_o.adr)) begin
                    wb_rsp_i.err = 1'b1;
                end else begin
                    wb_rsp_i.ack = 1'b1;
                    wb_rsp_i.dat = mem_read(wb_req_o.adr);
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // Compare each result pulse with the reference outcome
    always @(negedge clk_i) begin
        if (rst_ni && (done_o || error_o)) begin
            if (!exp_armed) begin
                $display("Result pulse seen with no walk outstanding");
                abort_run();
            end
            check_eq("done_o", 256'(done_o), 256'(exp_ok));
            check_eq("error_o", 256'(error_o), 256'(!exp_ok));
            if (exp_ok) begin
                check_eq("did_o", 256'(did_o), 256'(exp_did));
                check_eq("dc_o", 256'(dc_o), exp_dc);
            end else begin
                check_eq("cause_o", 256'(cause_o), 256'(exp_cause));
            end
            exp_armed = 1'b0;
            n_results = n_results + 1;
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the walks did not all finish", cycles);
            abort_run();
        end
    end

    initial begin
        clk_i = 1'b0;
        rst_ni = 1'b0;
        start_i = 1'b0;
        did_i = '0;
        ddtp_ppn_i = '0;
        ddtp_mode_i = DDT_OFF;
        caps_i = caps_t'(4'hf);
        wb_rsp_i = '0;
        next_ppn = 44'h0_0000_1000;
        stim_seed = SEED;
        slave_seed = SEED;
        exp_armed = 1'b0;
        exp_ok = 1'b0;
        exp_cause = '0;
        exp_dc = '0;
        exp_did = '0;
        n_results = 0;
        cycles = 0;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        // Quiet bus and no result before the first start
        repeat (3) begin
            @(negedge clk_i);
            check_eq("busy_o", 256'(busy_o), '0);
            check_eq("done_o", 256'(done_o), '0);
            check_eq("error_o", 256'(error_o), '0);
            check_eq("wb_req_o.cyc", 256'(wb_req_o.cyc), '0);
            check_eq("wb_req_o.stb", 256'(wb_req_o.stb), '0);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        repeat (5) @(negedge clk_i);
        if (n_results == NUM_TESTS && !exp_armed) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
